/* bench/rv_top_tb.sv */
/*
 testbench for the RV32I core
 runs the program held by tb_memory and checks reset behavior, the memory
 handshake, output port values, the data store and halt
*/
`include "rv_settings.svh"

module rv_top_tb;

    localparam int NUM_OUTPUTS = 17;
    localparam int HALT_TIMEOUT = 4000;
    localparam int QUIET_WINDOW = 40;
    // sw x10, 8(x12) with x12 = 512 and x10 = 0x797
    localparam logic [31:0] STORE_ADDR = 32'd520;
    localparam logic [31:0] STORE_DATA = 32'h0000_0797;
    // the halt store is the 53rd instruction
    localparam logic [31:0] HALT_PC = `RESET_PC + 32'd208;

    logic clk;
    logic rst;
    logic [`DATA_WIDTH-1:0] mem_rd_data;
    logic mem_ack;
    logic [`ADDR_WIDTH-1:0] mem_addr;
    logic [`DATA_WIDTH-1:0] mem_wr_data;
    logic mem_rd_req;
    logic mem_wr_req;
    logic [`DATA_WIDTH-1:0] out;
    logic outen;
    logic halt;
    logic [`ADDR_WIDTH-1:0] pc;

    // monitor state
    int value_errors = 0;
    int protocol_errors = 0;
    int out_index = 0;
    int store_count = 0;
    logic outstanding = 1'b0;
    logic first_read_seen = 1'b0;
    logic left_reset = 1'b0;
    logic halt_seen = 1'b0;

    // main sequence state
    int end_errors;
    int timeouts;
    int wait_cycles;

    rv_top rv_top_inst (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .out         (out),
        .outen       (outen),
        .halt        (halt),
        .pc          (pc)
    );

    tb_memory memory_inst (
        .clk         (clk),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // output port values in program order with x1 = 100, x2 = -7 and x6 = -16
    function automatic logic [31:0] expected_out(input int n);
        case (n)
            0:  return 32'd100 + 32'd7;
            // -7 < 100 signed, but 0xfffffff9 > 100 unsigned
            1:  return 32'd1;
            2:  return 32'd0;
            // -16 shifted right by 2 with sign fill and with zero fill
            3:  return 32'hffff_fffc;
            4:  return 32'h3fff_fffc;
            5:  return 32'h0000_0064 ^ 32'h0000_00f0;
            6:  return 32'h0000_0094 | 32'h0000_0703;
            7:  return 32'h0000_0797 & 32'h0000_00ff;
            // markers of the not-taken beq, bne, blt and bgeu
            8:  return 32'd107;
            9:  return 32'd0;
            10: return 32'h3fff_fffc;
            11: return 32'h0000_0797;
            12: return STORE_DATA;
            // jal link, auipc, lui and jalr link
            13: return `RESET_PC + 32'd168;
            14: return `RESET_PC + 32'd176 + 32'h0001_2000;
            15: return 32'habcd_e000;
            16: return `RESET_PC + 32'd200;
            default: return '0;
        endcase
    endfunction

    task automatic confirm_idle();
        assert (!mem_rd_req && !mem_wr_req && !outen && !halt) else begin
            $display("ERROR reset: mem_rd_req=%h mem_wr_req=%h outen=%h halt=%h",
                     mem_rd_req, mem_wr_req, outen, halt);
            protocol_errors++;
        end
    endtask

    task automatic track_handshake();
        assert (!(mem_rd_req && mem_wr_req)) else begin
            $display("core raised read and write requests in the same cycle");
            protocol_errors++;
        end
        if (mem_ack) begin
            outstanding = 1'b0;
        end
        if (mem_rd_req || mem_wr_req) begin
            assert (!outstanding) else begin
                $display("core issued a memory request before the previous ack");
                protocol_errors++;
            end
            outstanding = 1'b1;
            if (!first_read_seen) begin
                first_read_seen = 1'b1;
                assert (mem_rd_req && mem_addr == `RESET_PC) else begin
                    $display("ERROR mem_addr: expected %h, got %h on the first fetch",
                             `RESET_PC, mem_addr);
                    value_errors++;
                end
            end
        end
    endtask

    task automatic compare_out();
        logic [31:0] want;
        if (out_index >= NUM_OUTPUTS) begin
            $display("output port strobed with %h after all expected values", out);
            value_errors++;
        end else begin
            want = expected_out(out_index);
            assert (out == want) else begin
                $display("ERROR out: expected %h, got %h at output %0d", want, out, out_index);
                value_errors++;
            end
        end
        out_index++;
    endtask

    task automatic inspect_store();
        assert (mem_addr == STORE_ADDR) else begin
            $display("ERROR mem_addr: expected %h, got %h on store", STORE_ADDR, mem_addr);
            value_errors++;
        end
        assert (mem_wr_data == STORE_DATA) else begin
            $display("ERROR mem_wr_data: expected %h, got %h", STORE_DATA, mem_wr_data);
            value_errors++;
        end
        store_count++;
    endtask

    task automatic watch_halt();
        assert (halt) else begin
            $display("halt dropped after it was raised");
            protocol_errors++;
        end
        assert (!mem_rd_req && !mem_wr_req) else begin
            $display("core issued a memory request after halt");
            protocol_errors++;
        end
    endtask

    // checks made while the program runs, once per falling edge
    always @(negedge clk) begin
        if (!rst || !left_reset) begin
            confirm_idle();
            left_reset = rst;
        end else begin
            track_handshake();
            if (outen) begin
                compare_out();
            end
            if (mem_wr_req) begin
                inspect_store();
            end
            if (halt) begin
                halt_seen = 1'b1;
            end
            if (halt_seen) begin
                watch_halt();
            end
        end
    end

    initial begin
        rst = 1'b0;
        end_errors = 0;
        timeouts = 0;
        wait_cycles = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        while (!halt && wait_cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!halt) begin
            $display("timed out after %0d cycles waiting for halt", wait_cycles);
            timeouts++;
        end else begin
            assert (out_index == NUM_OUTPUTS) else begin
                $display("saw %0d of %0d output values before halt", out_index, NUM_OUTPUTS);
                end_errors++;
            end
            assert (store_count == 1) else begin
                $display("expected one data store before halt, saw %0d", store_count);
                end_errors++;
            end
            assert (pc == HALT_PC) else begin
                $display("ERROR pc: expected %h, got %h at halt", HALT_PC, pc);
                end_errors++;
            end
            // halt must hold with the memory port quiet
            wait_cycles = 0;
            while (wait_cycles < QUIET_WINDOW) begin
                @(negedge clk);
                wait_cycles++;
            end
        end

        $display("errors: %0d value, %0d protocol, %0d end of run, %0d timeout",
                 value_errors, protocol_errors, end_errors, timeouts);
        if (value_errors + protocol_errors + end_errors + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* bench/tb_memory.sv */
/*
 memory model for the core testbench
 one word-addressed array that holds the hand-assembled test program at the
 reset address and a data area, every request is acknowledged after 1 to 3 cycles
*/
`include "rv_settings.svh"

module tb_memory (
    input  logic clk,
    input  logic [`ADDR_WIDTH-1:0] mem_addr,
    input  logic [`DATA_WIDTH-1:0] mem_wr_data,
    input  logic mem_rd_req,
    input  logic mem_wr_req,
    output logic [`DATA_WIDTH-1:0] mem_rd_data,
    output logic mem_ack
);

    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    logic [31:0] words [0:255];
    logic [7:0] load_ptr;
    logic [7:0] req_index;
    logic busy;
    int delay_left;
    integer seed;

    // instruction encoders, one per RV32I format
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw only
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic place(input logic [31:0] word);
        words[load_ptr] = word;
        load_ptr = load_ptr + 8'd1;
    endtask

    // sw rs, 0(x31) where x31 holds the output port address
    task automatic send_out(input logic [4:0] rs);
        place(s_type(12'd0, rs, 5'd31));
    endtask

    task automatic load_program();
        load_ptr = 8'(`RESET_PC >> 2);
        // x31 = 0xf4000 + 0x240, the output port
        place(u_type(20'h000f4, 5'd31, OPC_LUI));
        place(i_type(12'h240, 5'd31, 3'b000, 5'd31, OPC_IMM));
        // x1 = 100, x2 = -7, then sub, slt and sltu
        place(i_type(12'd100, 5'd0, 3'b000, 5'd1, OPC_IMM));
        place(i_type(12'hff9, 5'd0, 3'b000, 5'd2, OPC_IMM));
        place(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
        send_out(5'd3);
        place(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd4));
        send_out(5'd4);
        place(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd5));
        send_out(5'd5);
        // x6 = -16, srai and srli by 2
        place(i_type(12'hff0, 5'd0, 3'b000, 5'd6, OPC_IMM));
        place(i_type(12'h402, 5'd6, 3'b101, 5'd7, OPC_IMM));
        send_out(5'd7);
        place(i_type(12'h002, 5'd6, 3'b101, 5'd8, OPC_IMM));
        send_out(5'd8);
        place(i_type(12'h0f0, 5'd1, 3'b100, 5'd9, OPC_IMM));
        send_out(5'd9);
        place(i_type(12'h703, 5'd9, 3'b110, 5'd10, OPC_IMM));
        send_out(5'd10);
        place(i_type(12'h0ff, 5'd10, 3'b111, 5'd11, OPC_IMM));
        send_out(5'd11);
        // each branch skips its marker store when taken
        place(b_type(13'd8, 5'd1, 5'd1, 3'b000));
        send_out(5'd1);
        place(b_type(13'd8, 5'd2, 5'd1, 3'b000));
        send_out(5'd3);
        place(b_type(13'd8, 5'd2, 5'd1, 3'b001));
        send_out(5'd4);
        place(b_type(13'd8, 5'd2, 5'd2, 3'b001));
        send_out(5'd5);
        place(b_type(13'd8, 5'd1, 5'd2, 3'b100));
        send_out(5'd7);
        place(b_type(13'd8, 5'd2, 5'd1, 3'b100));
        send_out(5'd8);
        place(b_type(13'd8, 5'd1, 5'd2, 3'b111));
        send_out(5'd9);
        place(b_type(13'd8, 5'd2, 5'd1, 3'b111));
        send_out(5'd10);
        // store x10 to 512+8, load it back and send it out
        place(i_type(12'h200, 5'd0, 3'b000, 5'd12, OPC_IMM));
        place(s_type(12'd8, 5'd10, 5'd12));
        place(i_type(12'd8, 5'd12, 3'b010, 5'd13, OPC_LOAD));
        send_out(5'd13);
        // jal over a zero store, then link, auipc and lui values
        place(j_type(21'd8, 5'd15));
        send_out(5'd0);
        send_out(5'd15);
        place(u_type(20'h00012, 5'd16, OPC_AUIPC));
        send_out(5'd16);
        place(u_type(20'habcde, 5'd17, OPC_LUI));
        send_out(5'd17);
        // jalr to x18+12 skips one zero store
        place(u_type(20'h00000, 5'd18, OPC_AUIPC));
        place(i_type(12'd12, 5'd18, 3'b000, 5'd19, OPC_JALR));
        send_out(5'd0);
        send_out(5'd19);
        // store to the halt address
        place(s_type(12'd4, 5'd0, 5'd31));
    endtask

    initial begin
        seed = 32'h84ae;
        mem_ack = 1'b0;
        mem_rd_data = '0;
        busy = 1'b0;
        delay_left = 0;
        req_index = '0;
        // data area pattern is the inverted byte address
        for (int i = 0; i < 256; i++) begin
            words[8'(i)] = ~(32'(i) << 2);
        end
        load_program();
        forever begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (busy) begin
                delay_left = delay_left - 1;
                if (delay_left == 0) begin
                    busy = 1'b0;
                    mem_ack = 1'b1;
                    mem_rd_data = words[req_index];
                end
            end else if (mem_rd_req || mem_wr_req) begin
                req_index = mem_addr[9:2];
                if (mem_wr_req) begin
                    words[req_index] = mem_wr_data;
                end
                delay_left = 1 + int'($unsigned($random(seed)) % 32'd3);
                busy = 1'b1;
            end
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module rv_top_tb \
    -Mdir obj_dir -o rv_top_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rv_top_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* source/exec_unit.sv */
/*
 combinational execute stage for the latched instruction
 decodes immediates, runs the alu, resolves branches and jumps, forms the
 load/store address and tells the sequencer what the instruction needs
*/
`include "rv_settings.svh"

module exec_unit (
    input  rv_pkg::instr_u instr,
    input  logic [`ADDR_WIDTH-1:0] pc,
    output rv_pkg::exec_class_e exec_class,
    output logic [`DATA_WIDTH-1:0] result,
    output logic [`ADDR_WIDTH-1:0] next_pc,
    output logic [`ADDR_WIDTH-1:0] mem_address,
    output logic [`DATA_WIDTH-1:0] store_data,
    reg_file_if.reader rf
);
    import rv_pkg::*;

    logic [`DATA_WIDTH-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`DATA_WIDTH-1:0] op_a, op_b, alu_out;
    logic [4:0] shamt;
    logic is_op, sub_en, alu_legal;
    logic taken, branch_legal;
    logic [`ADDR_WIDTH-1:0] pc_plus4, load_addr, store_addr;

    assign rf.rs1_sel = instr.r.rs1;
    assign rf.rs2_sel = instr.r.rs2;
    assign store_data = rf.rs2_data;

    // immediates, each taken from its own view of the word
    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'b0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    assign is_op = instr.r.opcode == OP;
    assign op_a = rf.rs1_data;
    assign op_b = is_op ? rf.rs2_data : imm_i;
    assign shamt = op_b[4:0];
    assign sub_en = is_op && instr.r.funct7[5];

    // funct7 must be zero, except for sub, sra and srai
    assign alu_legal = (!is_op && instr.r.funct3 != F3_SLL && instr.r.funct3 != F3_SR)
                       || instr.r.funct7 == 7'h00
                       || (instr.r.funct7 == 7'h20
                           && (instr.r.funct3 == F3_SR || (is_op && instr.r.funct3 == F3_ADD)));

    always_comb begin
        alu_out = '0;
        case (instr.r.funct3)
            F3_ADD:  alu_out = sub_en ? op_a - op_b : op_a + op_b;
            F3_SLL:  alu_out = op_a << shamt;
            F3_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            F3_SLTU: alu_out = {31'b0, op_a < op_b};
            F3_XOR:  alu_out = op_a ^ op_b;
            F3_OR:   alu_out = op_a | op_b;
            F3_AND:  alu_out = op_a & op_b;
            F3_SR: begin
                // kept apart so the arithmetic shift stays signed
                if (instr.r.funct7[5]) begin
                    alu_out = $signed(op_a) >>> shamt;
                end else begin
                    alu_out = op_a >> shamt;
                end
            end
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        branch_legal = 1'b1;
        case (instr.b.funct3)
            F3_BEQ:  taken = rf.rs1_data == rf.rs2_data;
            F3_BNE:  taken = rf.rs1_data != rf.rs2_data;
            F3_BLT:  taken = $signed(rf.rs1_data) < $signed(rf.rs2_data);
            F3_BGE:  taken = $signed(rf.rs1_data) >= $signed(rf.rs2_data);
            F3_BLTU: taken = rf.rs1_data < rf.rs2_data;
            F3_BGEU: taken = rf.rs1_data >= rf.rs2_data;
            default: branch_legal = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + `ADDR_WIDTH'(4);
    assign load_addr = rf.rs1_data + imm_i;
    assign store_addr = rf.rs1_data + imm_s;

    always_comb begin
        exec_class = ILLEGAL;
        result = alu_out;
        next_pc = pc_plus4;
        mem_address = load_addr;
        case (instr.r.opcode)
            OP, OPIMM: exec_class = alu_legal ? WRITEBACK : ILLEGAL;
            LUI: begin
                result = imm_u;
                exec_class = WRITEBACK;
            end
            AUIPC: begin
                result = pc + imm_u;
                exec_class = WRITEBACK;
            end
            JAL: begin
                result = pc_plus4;
                next_pc = pc + imm_j;
                exec_class = WRITEBACK;
            end
            JALR: begin
                result = pc_plus4;
                next_pc = {load_addr[`ADDR_WIDTH-1:1], 1'b0};
                exec_class = (instr.i.funct3 == 3'b000) ? WRITEBACK : ILLEGAL;
            end
            BRANCH: begin
                if (taken) begin
                    next_pc = pc + imm_b;
                end
                exec_class = branch_legal ? JUMP_ONLY : ILLEGAL;
            end
            LOAD: exec_class = (instr.i.funct3 == F3_WORD) ? MEM_LOAD : ILLEGAL;
            STORE: begin
                mem_address = store_addr;
                if (instr.s.funct3 != F3_WORD) begin
                    exec_class = ILLEGAL;
                end else if (store_addr == `OUT_ADDR) begin
                    exec_class = PORT_OUT;
                end else if (store_addr == `HALT_ADDR) begin
                    exec_class = PORT_HALT;
                end else begin
                    exec_class = MEM_STORE;
                end
            end
            default: exec_class = ILLEGAL;
        endcase
    end

endmodule

/* source/reg_file.sv */
/*
 integer register file with two asynchronous reads and one clocked write
 x0 reads as zero, writes to it are dropped
*/
`include "rv_settings.svh"

module reg_file (
    input  logic clk,
    input  logic rst,
    reg_file_if.storage rf
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    // reads see the old value during a write cycle
    assign rf.rs1_data = regs[rf.rs1_sel];
    assign rf.rs2_data = regs[rf.rs2_sel];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // x0 stays at its reset value of zero
            if (rf.wr_en && rf.wr_sel != '0) begin
                regs[rf.wr_sel] <= rf.wr_data;
            end
        end
    end

endmodule

/* source/reg_file_if.sv */
/*
 register file port bundle: two read selects with their data and one write port
 exec_unit reads through it, seq_control writes, reg_file stores
*/
`include "rv_settings.svh"

interface reg_file_if;
    logic [`REG_SEL_WIDTH-1:0] rs1_sel;
    logic [`REG_SEL_WIDTH-1:0] rs2_sel;
    logic [`DATA_WIDTH-1:0] rs1_data;
    logic [`DATA_WIDTH-1:0] rs2_data;

    logic [`REG_SEL_WIDTH-1:0] wr_sel;
    logic [`DATA_WIDTH-1:0] wr_data;
    logic wr_en;

    modport reader (
        output rs1_sel,
        output rs2_sel,
        input  rs1_data,
        input  rs2_data
    );

    modport writer (
        output wr_sel,
        output wr_data,
        output wr_en
    );

    modport storage (
        input  rs1_sel,
        input  rs2_sel,
        output rs1_data,
        output rs2_data,
        input  wr_sel,
        input  wr_data,
        input  wr_en
    );
endinterface

/* source/rv_pkg.sv */
/*
 types shared by the core modules: opcodes, funct3 codes, the instruction
 word in its RV32I formats, the execution class and the sequencer states
*/
`include "rv_settings.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    // alu operations, shared by OP and OPIMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    // lw and sw
    localparam logic [2:0] F3_WORD = 3'b010;
    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [`REG_SEL_WIDTH-1:0] rs2;
            logic [`REG_SEL_WIDTH-1:0] rs1;
            logic [2:0] funct3;
            logic [`REG_SEL_WIDTH-1:0] rd;
            opcode_e opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [`REG_SEL_WIDTH-1:0] rs1;
            logic [2:0] funct3;
            logic [`REG_SEL_WIDTH-1:0] rd;
            opcode_e opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [`REG_SEL_WIDTH-1:0] rs2;
            logic [`REG_SEL_WIDTH-1:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            opcode_e opcode;
        } s;
        struct packed {
            logic imm12;
            logic [5:0] imm10_5;
            logic [`REG_SEL_WIDTH-1:0] rs2;
            logic [`REG_SEL_WIDTH-1:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic imm11;
            opcode_e opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [`REG_SEL_WIDTH-1:0] rd;
            opcode_e opcode;
        } u;
        struct packed {
            logic imm20;
            logic [9:0] imm10_1;
            logic imm11;
            logic [7:0] imm19_12;
            logic [`REG_SEL_WIDTH-1:0] rd;
            opcode_e opcode;
        } j;
    } instr_u;

    // what the sequencer has to do with the current instruction
    typedef enum logic [2:0] {
        WRITEBACK,
        JUMP_ONLY,
        MEM_LOAD,
        MEM_STORE,
        PORT_OUT,
        PORT_HALT,
        ILLEGAL
    } exec_class_e;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_INSTR,
        EXECUTE,
        WAIT_DATA,
        HALTED
    } seq_state_e;

endpackage

/* source/rv_settings.svh */
/*
 widths, reset fetch address and memory-mapped store addresses for the core
 included by every file that sizes a bus or compares against a mapped address
*/
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and address widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// register file geometry
`define REG_SEL_WIDTH 5
`define NUM_REGS 32

// first instruction fetch after reset
`define RESET_PC 32'd128

// a store to one of these never reaches memory
`define OUT_ADDR 32'd1000000
`define HALT_ADDR 32'd1000004

`endif

/* source/rv_top.sv */
/*
 top level of the RV32I core
 joins sequencer, execute unit and register file behind one memory
 request/ack port, the output port and the halt flag
*/
`include "rv_settings.svh"

module rv_top (
    input  logic clk,
    input  logic rst,
    input  logic [`DATA_WIDTH-1:0] mem_rd_data,
    input  logic mem_ack,
    output logic [`ADDR_WIDTH-1:0] mem_addr,
    output logic [`DATA_WIDTH-1:0] mem_wr_data,
    output logic mem_rd_req,
    output logic mem_wr_req,
    output logic [`DATA_WIDTH-1:0] out,
    output logic outen,
    output logic halt,
    output logic [`ADDR_WIDTH-1:0] pc
);
    import rv_pkg::*;

    instr_u instr;
    exec_class_e exec_class;
    logic [`DATA_WIDTH-1:0] result;
    logic [`DATA_WIDTH-1:0] store_data;
    logic [`ADDR_WIDTH-1:0] next_pc;
    logic [`ADDR_WIDTH-1:0] mem_address;

    reg_file_if rf_bus ();

    seq_control seq_control_inst (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .exec_class  (exec_class),
        .result      (result),
        .next_pc     (next_pc),
        .mem_address (mem_address),
        .store_data  (store_data),
        .instr       (instr),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .out         (out),
        .outen       (outen),
        .halt        (halt),
        .rf          (rf_bus.writer)
    );

    exec_unit exec_unit_inst (
        .instr       (instr),
        .pc          (pc),
        .exec_class  (exec_class),
        .result      (result),
        .next_pc     (next_pc),
        .mem_address (mem_address),
        .store_data  (store_data),
        .rf          (rf_bus.reader)
    );

    reg_file reg_file_inst (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus.storage)
    );

endmodule

/* source/seq_control.sv */
/*
 sequencer of the core: fetch, execute and data access one instruction at a time
 owns the pc, the instruction register, the memory request strobes, the output
 port and halt, and decides every register write
*/
`include "rv_settings.svh"

module seq_control (
    input  logic clk,
    input  logic rst,
    input  logic [`DATA_WIDTH-1:0] mem_rd_data,
    input  logic mem_ack,
    input  rv_pkg::exec_class_e exec_class,
    input  logic [`DATA_WIDTH-1:0] result,
    input  logic [`ADDR_WIDTH-1:0] next_pc,
    input  logic [`ADDR_WIDTH-1:0] mem_address,
    input  logic [`DATA_WIDTH-1:0] store_data,
    output rv_pkg::instr_u instr,
    output logic [`ADDR_WIDTH-1:0] pc,
    output logic [`ADDR_WIDTH-1:0] mem_addr,
    output logic [`DATA_WIDTH-1:0] mem_wr_data,
    output logic mem_rd_req,
    output logic mem_wr_req,
    output logic [`DATA_WIDTH-1:0] out,
    output logic outen,
    output logic halt,
    reg_file_if.writer rf
);
    import rv_pkg::*;

    seq_state_e state, state_next;
    logic issue_rd, issue_wr, emit_out, advance_pc;
    logic [`ADDR_WIDTH-1:0] req_addr;

    // next state and the requests raised on leaving this cycle
    always_comb begin
        state_next = state;
        issue_rd = 1'b0;
        issue_wr = 1'b0;
        emit_out = 1'b0;
        advance_pc = 1'b0;
        req_addr = next_pc;
        case (state)
            FETCH: begin
                issue_rd = 1'b1;
                req_addr = pc;
                state_next = WAIT_INSTR;
            end
            WAIT_INSTR: begin
                if (mem_ack) begin
                    state_next = EXECUTE;
                end
            end
            EXECUTE: begin
                case (exec_class)
                    WRITEBACK, JUMP_ONLY, PORT_OUT: begin
                        emit_out = exec_class == PORT_OUT;
                        issue_rd = 1'b1;
                        advance_pc = 1'b1;
                        state_next = WAIT_INSTR;
                    end
                    MEM_LOAD: begin
                        issue_rd = 1'b1;
                        req_addr = mem_address;
                        state_next = WAIT_DATA;
                    end
                    MEM_STORE: begin
                        issue_wr = 1'b1;
                        req_addr = mem_address;
                        state_next = WAIT_DATA;
                    end
                    // halt store or an instruction we cannot run
                    default: state_next = HALTED;
                endcase
            end
            WAIT_DATA: begin
                // instr and pc are unchanged here, so next_pc is still pc+4
                if (mem_ack) begin
                    issue_rd = 1'b1;
                    advance_pc = 1'b1;
                    state_next = WAIT_INSTR;
                end
            end
            default: state_next = HALTED;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= FETCH;
            pc <= `RESET_PC;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            outen <= 1'b0;
        end else begin
            state <= state_next;
            if (advance_pc) begin
                pc <= next_pc;
            end
            mem_rd_req <= issue_rd;
            mem_wr_req <= issue_wr;
            outen <= emit_out;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_rd || issue_wr) begin
            mem_addr <= req_addr;
        end
        if (issue_wr) begin
            mem_wr_data <= store_data;
        end
        if (emit_out) begin
            out <= store_data;
        end
        if (state == WAIT_INSTR && mem_ack) begin
            instr <= instr_u'(mem_rd_data);
        end
    end

    assign halt = state == HALTED;

    // alu result in execute, load data when the data ack arrives
    assign rf.wr_sel = instr.r.rd;
    assign rf.wr_data = (state == WAIT_DATA) ? mem_rd_data : result;
    assign rf.wr_en = (state == EXECUTE && exec_class == WRITEBACK)
                      || (state == WAIT_DATA && mem_ack && exec_class == MEM_LOAD);

endmodule

/* vlog.f */
+incdir+source
source/rv_pkg.sv
source/reg_file_if.sv
source/reg_file.sv
source/exec_unit.sv
source/seq_control.sv
source/rv_top.sv
bench/tb_memory.sv
bench/rv_top_tb.sv
